/* hdl/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Core bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// 4 KiB pages
`define MEM_PAGE_OFS_W 12

// Link bit comes up cleared
`define MEM_LLBIT_RST 1'b0

`endif

/* hdl/mem_op_pkg.sv */
`include "mem_defines.svh"

package mem_op_pkg;

    typedef logic [`MEM_DATA_W-1:0]                 word_t;
    typedef logic [`MEM_ADDR_W-1:0]                 addr_t;
    typedef logic [`MEM_DATA_W/8-1:0]               strb_t;
    typedef logic [4:0]                             reg_idx_t;
    typedef logic [`MEM_ADDR_W-`MEM_PAGE_OFS_W-1:0] ppn_t;

    typedef enum logic [3:0] {
        LD_B  = 4'd0,
        LD_BU = 4'd1,
        LD_H  = 4'd2,
        LD_HU = 4'd3,
        LD_W  = 4'd4,
        ST_B  = 4'd5,
        ST_H  = 4'd6,
        ST_W  = 4'd7,
        LL_W  = 4'd8,
        SC_W  = 4'd9
    } mem_op_e;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } acc_size_e;

endpackage

/* hdl/mem_excp_pkg.sv */
package mem_excp_pkg;

    // Privilege level, 0 is the most privileged
    typedef logic [1:0] plv_t;

    // TLB memory access type
    typedef logic [1:0] mat_t;

    typedef enum logic [3:0] {
        NONE = 4'd0,
        ADEM = 4'd1,
        ALE  = 4'd2,
        TLBR = 4'd3,
        PIL  = 4'd4,
        PIS  = 4'd5,
        PPI  = 4'd6,
        PME  = 4'd7
    } excp_e;

endpackage

/* hdl/mem_op_decode.sv */
module mem_op_decode
    import mem_op_pkg::*;
(
    input  mem_op_e   op_i,
    output acc_size_e size_o,
    output logic      signed_o,
    output logic      load_o,
    output logic      store_o,
    output logic      link_o,
    output logic      cond_o
);

    always_comb begin
        size_o   = ACC_WORD;
        signed_o = 1'b0;
        load_o   = 1'b0;
        store_o  = 1'b0;
        link_o   = 1'b0;
        cond_o   = 1'b0;
        case (op_i)
            LD_B, LD_BU: begin
                size_o   = ACC_BYTE;
                signed_o = (op_i == LD_B);
                load_o   = 1'b1;
            end
            LD_H, LD_HU: begin
                size_o   = ACC_HALF;
                signed_o = (op_i == LD_H);
                load_o   = 1'b1;
            end
            LD_W: load_o = 1'b1;
            ST_B: begin
                size_o  = ACC_BYTE;
                store_o = 1'b1;
            end
            ST_H: begin
                size_o  = ACC_HALF;
                store_o = 1'b1;
            end
            ST_W: store_o = 1'b1;
            // LL is a linked word load, SC a conditional word store
            LL_W: begin
                load_o = 1'b1;
                link_o = 1'b1;
            end
            SC_W: begin
                store_o = 1'b1;
                cond_o  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/mem_access_check.sv */
`include "mem_defines.svh"

module mem_access_check
    import mem_op_pkg::*;
    import mem_excp_pkg::*;
(
    input  addr_t     vaddr_i,
    input  acc_size_e size_i,
    input  logic      load_i,
    input  logic      store_i,
    input  logic      cond_i,
    input  logic      trans_en_i,
    input  plv_t      plv_i,
    input  logic      tlb_found_i,
    input  logic      tlb_v_i,
    input  logic      tlb_d_i,
    input  plv_t      tlb_plv_i,
    input  ppn_t      tlb_ppn_i,
    input  logic      llbit_i,
    output addr_t     paddr_o,
    output excp_e     excp_o,
    output logic      sc_fail_o
);

    logic access;
    logic misaligned;

    assign access = load_i | store_i;

    assign paddr_o = trans_en_i ? {tlb_ppn_i, vaddr_i[`MEM_PAGE_OFS_W-1:0]} : vaddr_i;

    always_comb begin
        case (size_i)
            ACC_HALF: misaligned = vaddr_i[0];
            ACC_WORD: misaligned = |vaddr_i[1:0];
            default:  misaligned = 1'b0;
        endcase
    end

    // First match wins
    always_comb begin
        excp_o = NONE;
        if (access) begin
            if (trans_en_i && plv_i == 2'd3 && vaddr_i[`MEM_ADDR_W-1]) begin
                excp_o = ADEM;
            end else if (misaligned) begin
                excp_o = ALE;
            end else if (trans_en_i && !tlb_found_i) begin
                excp_o = TLBR;
            end else if (trans_en_i && !tlb_v_i) begin
                excp_o = load_i ? PIL : PIS;
            end else if (trans_en_i && plv_i > tlb_plv_i) begin
                excp_o = PPI;
            end else if (trans_en_i && store_i && !tlb_d_i) begin
                excp_o = PME;
            end
        end
    end

    // SC without a live link never reaches the bus
    assign sc_fail_o = cond_i & ~llbit_i & (excp_o == NONE);

endmodule

/* hdl/mem_bus_request.sv */
`include "mem_defines.svh"

module mem_bus_request
    import mem_op_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  logic      store_i,
    input  acc_size_e size_i,
    input  addr_t     paddr_i,
    input  word_t     wdata_i,
    output addr_t     awaddr_o,
    output logic      awvalid_o,
    input  logic      awready_i,
    output word_t     wdata_o,
    output strb_t     wstrb_o,
    output logic      wvalid_o,
    input  logic      wready_i,
    input  logic      bvalid_i,
    output logic      bready_o,
    output addr_t     araddr_o,
    output logic      arvalid_o,
    input  logic      arready_i,
    input  word_t     rdata_i,
    input  logic      rvalid_i,
    output logic      rready_o,
    output logic      done_o,
    output word_t     rdata_o
);

    typedef enum logic [2:0] {IDLE, WRITE, WRESP, READ, RRESP, DONE} state_e;

    state_e state;
    logic   aw_pend;
    logic   w_pend;
    addr_t  addr_q;
    strb_t  strb;
    word_t  lane_data;

    // Shift store data into the lane picked by the low address bits
    always_comb begin
        case (size_i)
            ACC_BYTE: begin
                strb      = strb_t'(4'b0001) << paddr_i[1:0];
                lane_data = word_t'(wdata_i[7:0]) << {paddr_i[1:0], 3'b000};
            end
            ACC_HALF: begin
                strb      = strb_t'(4'b0011) << paddr_i[1:0];
                lane_data = word_t'(wdata_i[15:0]) << {paddr_i[1:0], 3'b000};
            end
            default: begin
                strb      = '1;
                lane_data = wdata_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i && store_i) begin
                        state   <= WRITE;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end else if (start_i) begin
                        state <= READ;
                    end
                end
                // AW and W complete independently
                WRITE: begin
                    if (awready_i) begin
                        aw_pend <= 1'b0;
                    end
                    if (wready_i) begin
                        w_pend <= 1'b0;
                    end
                    if ((!aw_pend || awready_i) && (!w_pend || wready_i)) begin
                        state <= WRESP;
                    end
                end
                WRESP: state <= bvalid_i ? DONE : WRESP;
                READ: state <= arready_i ? RRESP : READ;
                RRESP: state <= rvalid_i ? DONE : RRESP;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            addr_q  <= {paddr_i[`MEM_ADDR_W-1:2], 2'b00};
            wdata_o <= lane_data;
            wstrb_o <= strb;
        end
        if (state == RRESP && rvalid_i) begin
            rdata_o <= rdata_i;
        end
    end

    assign awaddr_o  = addr_q;
    assign araddr_o  = addr_q;
    assign awvalid_o = aw_pend;
    assign wvalid_o  = w_pend;
    assign bready_o  = (state == WRESP);
    assign arvalid_o = (state == READ);
    assign rready_o  = (state == RRESP);
    assign done_o    = (state == DONE);

endmodule

/* hdl/mem_stage_result.sv */
`include "mem_defines.svh"

module mem_stage_result
    import mem_op_pkg::*;
    import mem_excp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      accept_i,
    input  logic      done_i,
    input  word_t     rdata_i,
    input  logic [1:0] paddr_lo_i,
    input  acc_size_e size_i,
    input  logic      signed_i,
    input  logic      load_i,
    input  logic      link_i,
    input  logic      cond_i,
    input  logic      sc_fail_i,
    input  excp_e     excp_i,
    input  addr_t     vaddr_i,
    input  reg_idx_t  rd_i,
    output logic      llbit_o,
    output logic      out_valid_o,
    output logic      rd_we_o,
    output reg_idx_t  rd_o,
    output word_t     rd_data_o,
    output excp_e     excp_o,
    output addr_t     badv_o,
    input  logic      out_ready_i
);

    logic  clean;
    logic  finish;
    word_t lane;
    word_t load_val;

    assign clean  = (excp_i == NONE);
    assign finish = done_i | (accept_i & (~clean | sc_fail_i));
    assign lane   = rdata_i >> {paddr_lo_i, 3'b000};

    always_comb begin
        case (size_i)
            ACC_BYTE: load_val = signed_i ? {{(`MEM_DATA_W-8){lane[7]}}, lane[7:0]}
                                          : {{(`MEM_DATA_W-8){1'b0}}, lane[7:0]};
            ACC_HALF: load_val = signed_i ? {{(`MEM_DATA_W-16){lane[15]}}, lane[15:0]}
                                          : {{(`MEM_DATA_W-16){1'b0}}, lane[15:0]};
            default:  load_val = lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            rd_o   <= rd_i;
            excp_o <= excp_i;
            badv_o <= clean ? '0 : vaddr_i;
            if (!clean) begin
                rd_we_o   <= 1'b0;
                rd_data_o <= '0;
            end else if (cond_i) begin
                // SC reports 1 on success, 0 on failure
                rd_we_o   <= 1'b1;
                rd_data_o <= sc_fail_i ? '0 : word_t'(1);
            end else begin
                rd_we_o   <= load_i;
                rd_data_o <= load_i ? load_val : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
            llbit_o     <= `MEM_LLBIT_RST;
        end else begin
            if (finish) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
            if (finish && clean && link_i) begin
                llbit_o <= 1'b1;
            end else if (finish && clean && cond_i) begin
                llbit_o <= 1'b0;
            end
        end
    end

endmodule

/* hdl/mem_stage_top.sv */
module mem_stage_top
    import mem_op_pkg::*;
    import mem_excp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  mem_op_e  op_i,
    input  addr_t    vaddr_i,
    input  word_t    wdata_i,
    input  reg_idx_t rd_i,
    input  logic     trans_en_i,
    input  plv_t     plv_i,
    input  logic     tlb_found_i,
    input  logic     tlb_v_i,
    input  logic     tlb_d_i,
    input  plv_t     tlb_plv_i,
    input  ppn_t     tlb_ppn_i,
    output addr_t    awaddr_o,
    output logic     awvalid_o,
    input  logic     awready_i,
    output word_t    wdata_o,
    output strb_t    wstrb_o,
    output logic     wvalid_o,
    input  logic     wready_i,
    input  logic     bvalid_i,
    output logic     bready_o,
    output addr_t    araddr_o,
    output logic     arvalid_o,
    input  logic     arready_i,
    input  word_t    rdata_i,
    input  logic     rvalid_i,
    output logic     rready_o,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output logic     rd_we_o,
    output reg_idx_t rd_o,
    output word_t    rd_data_o,
    output excp_e    excp_o,
    output addr_t    badv_o
);

    logic      busy;
    logic      fresh;
    logic      accept;
    logic      start;
    mem_op_e   op_q;
    addr_t     vaddr_q;
    word_t     wdata_q;
    reg_idx_t  rd_q;
    logic      trans_en_q;
    plv_t      plv_q;
    logic      tlb_found_q;
    logic      tlb_v_q;
    logic      tlb_d_q;
    plv_t      tlb_plv_q;
    ppn_t      tlb_ppn_q;
    acc_size_e size;
    logic      is_signed;
    logic      is_load;
    logic      is_store;
    logic      is_link;
    logic      is_cond;
    addr_t     paddr;
    excp_e     excp;
    logic      sc_fail;
    logic      llbit;
    logic      bus_done;
    word_t     bus_rdata;

    assign in_ready_o = ~busy;
    assign accept     = in_valid_i & in_ready_o;
    // Only a clean access goes out on the bus
    assign start      = fresh & (excp == NONE) & ~sc_fail;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            fresh <= 1'b0;
        end else begin
            fresh <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (out_valid_o && out_ready_i) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q        <= op_i;
            vaddr_q     <= vaddr_i;
            wdata_q     <= wdata_i;
            rd_q        <= rd_i;
            trans_en_q  <= trans_en_i;
            plv_q       <= plv_i;
            tlb_found_q <= tlb_found_i;
            tlb_v_q     <= tlb_v_i;
            tlb_d_q     <= tlb_d_i;
            tlb_plv_q   <= tlb_plv_i;
            tlb_ppn_q   <= tlb_ppn_i;
        end
    end

    mem_op_decode mem_op_decode_inst (
        .op_i(op_q), .size_o(size), .signed_o(is_signed), .load_o(is_load),
        .store_o(is_store), .link_o(is_link), .cond_o(is_cond)
    );

    mem_access_check mem_access_check_inst (
        .vaddr_i(vaddr_q), .size_i(size), .load_i(is_load), .store_i(is_store),
        .cond_i(is_cond), .trans_en_i(trans_en_q), .plv_i(plv_q),
        .tlb_found_i(tlb_found_q), .tlb_v_i(tlb_v_q), .tlb_d_i(tlb_d_q),
        .tlb_plv_i(tlb_plv_q), .tlb_ppn_i(tlb_ppn_q), .llbit_i(llbit),
        .paddr_o(paddr), .excp_o(excp), .sc_fail_o(sc_fail)
    );

    mem_bus_request mem_bus_request_inst (
        .clk, .rst, .start_i(start), .store_i(is_store), .size_i(size),
        .paddr_i(paddr), .wdata_i(wdata_q),
        .awaddr_o, .awvalid_o, .awready_i, .wdata_o, .wstrb_o, .wvalid_o, .wready_i,
        .bvalid_i, .bready_o, .araddr_o, .arvalid_o, .arready_i, .rdata_i, .rvalid_i,
        .rready_o, .done_o(bus_done), .rdata_o(bus_rdata)
    );

    mem_stage_result mem_stage_result_inst (
        .clk, .rst, .accept_i(fresh), .done_i(bus_done), .rdata_i(bus_rdata),
        .paddr_lo_i(paddr[1:0]), .size_i(size), .signed_i(is_signed),
        .load_i(is_load), .link_i(is_link), .cond_i(is_cond), .sc_fail_i(sc_fail),
        .excp_i(excp), .vaddr_i(vaddr_q), .rd_i(rd_q), .llbit_o(llbit),
        .out_valid_o, .rd_we_o, .rd_o, .rd_data_o, .excp_o, .badv_o, .out_ready_i
    );

endmodule

/* verification/mem_stage_assert.sv */
module mem_stage_assert (
    input logic        clk,
    input logic        rst,
    input logic        awvalid_i,
    input logic        awready_i,
    input logic [31:0] awaddr_i,
    input logic        wvalid_i,
    input logic        wready_i,
    input logic [31:0] wdata_i,
    input logic [3:0]  wstrb_i,
    input logic        arvalid_i,
    input logic        arready_i,
    input logic [31:0] araddr_i,
    input logic        out_valid_i,
    input logic        out_ready_i,
    input logic        in_ready_i,
    input logic [31:0] rd_data_i
);

    int fail_count = 0;

    // Payload holds until the handshake
    aw_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin
            $error("AW payload changed while valid");
            fail_count++;
        end
    w_stable: assert property (@(posedge clk) disable iff (rst)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
        else begin
            $error("W payload changed while valid");
            fail_count++;
        end
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin
            $error("AR payload changed while valid");
            fail_count++;
        end
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(rd_data_i))
        else begin
            $error("Result record dropped before it was taken");
            fail_count++;
        end
    busy_while_pending: assert property (@(posedge clk) disable iff (rst)
        out_valid_i |-> !in_ready_i)
        else begin
            $error("Input accepted while a record is pending");
            fail_count++;
        end

endmodule

bind mem_stage_top mem_stage_assert mem_stage_assert_inst (
    .clk(clk), .rst(rst),
    .awvalid_i(awvalid_o), .awready_i(awready_i), .awaddr_i(awaddr_o),
    .wvalid_i(wvalid_o), .wready_i(wready_i), .wdata_i(wdata_o), .wstrb_i(wstrb_o),
    .arvalid_i(arvalid_o), .arready_i(arready_i), .araddr_i(araddr_o),
    .out_valid_i(out_valid_o), .out_ready_i(out_ready_i), .in_ready_i(in_ready_o),
    .rd_data_i(rd_data_o)
);

/* verification/mem_stage_tb.sv */
module mem_stage_tb
    import mem_op_pkg::*;
    import mem_excp_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     in_valid_i;
    logic     in_ready_o;
    mem_op_e  op_i;
    addr_t    vaddr_i;
    word_t    wdata_i;
    reg_idx_t rd_i;
    logic     trans_en_i;
    plv_t     plv_i;
    logic     tlb_found_i;
    logic     tlb_v_i;
    logic     tlb_d_i;
    plv_t     tlb_plv_i;
    ppn_t     tlb_ppn_i;
    addr_t    awaddr_o;
    logic     awvalid_o;
    logic     awready_i;
    word_t    wdata_o;
    strb_t    wstrb_o;
    logic     wvalid_o;
    logic     wready_i;
    logic     bvalid_i;
    logic     bready_o;
    addr_t    araddr_o;
    logic     arvalid_o;
    logic     arready_i;
    word_t    rdata_i;
    logic     rvalid_i;
    logic     rready_o;
    logic     out_valid_o;
    logic     out_ready_i;
    logic     rd_we_o;
    reg_idx_t rd_o;
    word_t    rd_data_o;
    excp_e    excp_o;
    addr_t    badv_o;

    word_t       mem [0:255];
    string       lines [$];
    logic [31:0] lfsr_state;
    addr_t       exp_addr;
    int          access_count;
    int          errors;
    int          failed_tests;
    int          cycles;
    int          cycle_limit;

    mem_stage_top mem_stage_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Slave side of the AXI4-Lite port
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (awvalid_o) begin
                wait_cycles(random_bits(2));
                check_value("awaddr_o", awaddr_o, exp_addr);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_o[b]) begin
                        mem[awaddr_o[9:2]][8*b +: 8] = wdata_o[8*b +: 8];
                    end
                end
                access_count++;
                awready_i = 1'b1;
                wready_i  = 1'b1;
                wait_cycles(1);
                awready_i = 1'b0;
                wready_i  = 1'b0;
                wait_cycles(random_bits(2));
                while (!bready_o) begin
                    wait_cycles(1);
                end
                bvalid_i = 1'b1;
                wait_cycles(1);
                bvalid_i = 1'b0;
            end else if (arvalid_o) begin
                wait_cycles(random_bits(2));
                check_value("araddr_o", araddr_o, exp_addr);
                access_count++;
                arready_i = 1'b1;
                wait_cycles(1);
                arready_i = 1'b0;
                wait_cycles(random_bits(2));
                while (!rready_o) begin
                    wait_cycles(1);
                end
                rdata_i  = mem[araddr_o[9:2]];
                rvalid_i = 1'b1;
                wait_cycles(1);
                rvalid_i = 1'b0;
            end
        end
    end

    initial begin
        wait (cycle_limit != 0);
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout, the DUT made no progress within %0d cycles", cycle_limit);
                $display("test failed");
                $finish;
            end
        end
    end

    task automatic run_test(input string line, input int num);
        logic [31:0] f_op, f_vaddr, f_wdata, f_rd, f_tr, f_plv, f_fnd, f_v, f_d;
        logic [31:0] f_tplv, f_ppn, f_pre_en, f_pre, f_we, f_data, f_excp, f_acc, f_mem;
        logic [31:0] paddr;
        int          n;
        int          wait_cyc;
        int          valid_cyc;
        int          errs_before;
        logic        seen;
        errs_before = errors;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_op, f_vaddr, f_wdata, f_rd, f_tr, f_plv, f_fnd, f_v, f_d,
                    f_tplv, f_ppn, f_pre_en, f_pre, f_we, f_data, f_excp, f_acc, f_mem);
        if (n != 18) begin
            $display("Test %0d has a malformed line in the input file", num);
            errors++;
            failed_tests++;
            return;
        end
        paddr = f_tr[0] ? {f_ppn[19:0], f_vaddr[11:0]} : f_vaddr;
        exp_addr = {paddr[31:2], 2'b00};
        if (f_pre_en[0]) begin
            mem[paddr[9:2]] = f_pre;
        end
        access_count = 0;
        op_i        = mem_op_e'(f_op[3:0]);
        vaddr_i     = f_vaddr;
        wdata_i     = f_wdata;
        rd_i        = f_rd[4:0];
        trans_en_i  = f_tr[0];
        plv_i       = f_plv[1:0];
        tlb_found_i = f_fnd[0];
        tlb_v_i     = f_v[0];
        tlb_d_i     = f_d[0];
        tlb_plv_i   = f_tplv[1:0];
        tlb_ppn_i   = f_ppn[19:0];
        in_valid_i  = 1'b1;
        while (!in_ready_o) begin
            wait_cycles(1);
        end
        wait_cycles(1);
        in_valid_i = 1'b0;
        wait_cyc = 0;
        valid_cyc = -1;
        seen = 1'b0;
        while (!seen) begin
            out_ready_i = (random_bits(2) != 0);
            assert (!in_ready_o) else begin
                $display("Test %0d: in_ready_o went high while a record was pending", num);
                errors++;
            end
            if (out_valid_o && valid_cyc < 0) begin
                valid_cyc = wait_cyc;
            end
            if (out_valid_o && out_ready_i) begin
                seen = 1'b1;
            end else begin
                wait_cycles(1);
                wait_cyc++;
            end
        end
        check_value("rd_we_o", rd_we_o, f_we);
        check_value("rd_data_o", rd_data_o, f_data);
        check_value("excp_o", excp_o, f_excp);
        if (f_we[0]) begin
            check_value("rd_o", rd_o, f_rd);
        end
        if (f_excp != 0) begin
            check_value("badv_o", badv_o, f_vaddr);
        end
        if (f_acc == 0) begin
            assert (valid_cyc == 1) else begin
                $display("Test %0d: record without bus access took %0d cycles", num, valid_cyc);
                errors++;
            end
        end
        wait_cycles(1);
        out_ready_i = 1'b0;
        assert (!out_valid_o) else begin
            $display("Test %0d: the same record was offered a second time", num);
            errors++;
        end
        check_value("access_count", access_count, f_acc);
        check_value("mem word", mem[paddr[9:2]], f_mem);
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("Test %0d %s", num, (errors == errs_before) ? "ok" : "with errors");
    endtask

    initial begin
        int    fd;
        string line;
        rst = 1'b1;
        in_valid_i = 1'b0;
        op_i = LD_W;
        vaddr_i = '0;
        wdata_i = '0;
        rd_i = '0;
        trans_en_i = 1'b0;
        plv_i = '0;
        tlb_found_i = 1'b0;
        tlb_v_i = 1'b0;
        tlb_d_i = 1'b0;
        tlb_plv_i = '0;
        tlb_ppn_i = '0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        bvalid_i = 1'b0;
        arready_i = 1'b0;
        rdata_i = '0;
        rvalid_i = 1'b0;
        out_ready_i = 1'b0;
        lfsr_state = 32'hb24e1124;
        errors = 0;
        failed_tests = 0;
        cycles = 0;
        cycle_limit = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
        fd = $fopen("verification/mem_stage_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input file");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = lines.size() * 20 + 10;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (lines[i]) begin
            run_test(lines[i], i);
        end
        errors += mem_stage_top_inst.mem_stage_assert_inst.fail_count;
        $display("%0d tests run, %0d failed, %0d errors", lines.size(), failed_tests, errors);
        if (errors == 0 && lines.size() > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verification/mem_stage_input.txt */
# op vaddr wdata rd trans_en plv tlb_found tlb_v tlb_d tlb_plv tlb_ppn
# preload_en preload exp_we exp_data exp_excp exp_access_count exp_mem_word (all hex)
0 00000010 00000000 01 0 0 0 0 0 0 00000 1 8899aabb 1 ffffffbb 0 1 8899aabb
1 00000011 00000000 02 0 0 0 0 0 0 00000 0 00000000 1 000000aa 0 1 8899aabb
0 00000012 00000000 03 0 0 0 0 0 0 00000 0 00000000 1 ffffff99 0 1 8899aabb
1 00000013 00000000 04 0 0 0 0 0 0 00000 0 00000000 1 00000088 0 1 8899aabb
2 00000010 00000000 05 0 0 0 0 0 0 00000 0 00000000 1 ffffaabb 0 1 8899aabb
3 00000012 00000000 06 0 0 0 0 0 0 00000 0 00000000 1 00008899 0 1 8899aabb
4 00000010 00000000 07 0 0 0 0 0 0 00000 0 00000000 1 8899aabb 0 1 8899aabb
5 00000021 000000cc 08 0 0 0 0 0 0 00000 1 11223344 0 00000000 0 1 1122cc44
6 00000022 0000beef 09 0 0 0 0 0 0 00000 0 00000000 0 00000000 0 1 beefcc44
4 00000020 00000000 0a 0 0 0 0 0 0 00000 0 00000000 1 beefcc44 0 1 beefcc44
7 00000024 deadbeef 0b 0 0 0 0 0 0 00000 1 00000000 0 00000000 0 1 deadbeef
2 00000031 00000000 0c 0 0 0 0 0 0 00000 1 55555555 0 00000000 2 0 55555555
4 80000042 00000000 0d 1 3 1 1 1 3 00000 1 66666666 0 00000000 1 0 66666666
4 00001050 00000000 0e 1 0 0 0 0 0 00000 1 01010101 0 00000000 3 0 01010101
7 00002060 12121212 0f 1 0 1 0 0 0 00000 1 02020202 0 00000000 5 0 02020202
4 00003070 00000000 10 1 3 1 1 1 0 00000 1 03030303 0 00000000 6 0 03030303
7 00004080 34343434 11 1 0 1 1 0 0 00000 1 04040404 0 00000000 7 0 04040404
4 7fff5090 00000000 12 1 0 1 1 1 0 00001 1 0a0b0c0d 1 0a0b0c0d 0 1 0a0b0c0d
7 12345094 cafef00d 13 1 0 1 1 1 0 00002 1 00000000 0 00000000 0 1 cafef00d
9 000000a0 00000001 14 0 0 0 0 0 0 00000 1 77777777 1 00000000 0 0 77777777
8 000000a0 00000000 15 0 0 0 0 0 0 00000 0 00000000 1 77777777 0 1 77777777
9 000000a0 12345678 16 0 0 0 0 0 0 00000 0 00000000 1 00000001 0 1 12345678
9 000000a0 9abcdef0 17 0 0 0 0 0 0 00000 0 00000000 1 00000000 0 0 12345678

/* sim.f */
+incdir+hdl
hdl/mem_op_pkg.sv
hdl/mem_excp_pkg.sv
hdl/mem_op_decode.sv
hdl/mem_access_check.sv
hdl/mem_bus_request.sv
hdl/mem_stage_result.sv
hdl/mem_stage_top.sv
verification/mem_stage_assert.sv
verification/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_op_pkg.sv
      - hdl/mem_excp_pkg.sv
      - hdl/mem_op_decode.sv
      - hdl/mem_access_check.sv
      - hdl/mem_bus_request.sv
      - hdl/mem_stage_result.sv
      - hdl/mem_stage_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/mem_stage_assert.sv
      - verification/mem_stage_tb.sv
